// ==== rtl/elev_pkg.sv ====
package elev_pkg;

    // ************************************************************
    // building limits and phase lengths in ticks
    // ************************************************************
    localparam int MIN_FLOOR    = 1;
    localparam int MAX_FLOOR    = 32;
    localparam int FLOOR_BITS   = 6;
    localparam int START_FLOOR  = 1;
    localparam int DOOR_TICKS   = 1;   // open or close motion
    localparam int DWELL_TICKS  = 3;
    localparam int TRAVEL_TICKS = 2;   // one floor
    localparam int TIMER_BITS   = 8;

    typedef logic [FLOOR_BITS-1:0]      floor_t;
    typedef logic [MAX_FLOOR:MIN_FLOOR] floor_map_t;  // bit n is floor n

    // call opcode
    typedef enum logic [1:0] {
        CALL_HALL_UP = 2'd0,
        CALL_HALL_DN = 2'd1,
        CALL_CAR     = 2'd2
    } call_kind_e;

    typedef struct packed {
        call_kind_e kind;
        floor_t     floor;
    } call_req_t;

    typedef struct packed {
        floor_map_t hall_up;
        floor_map_t hall_dn;
        floor_map_t car;
    } call_maps_t;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_DOOR_OPEN  = 3'd1,
        ST_DWELL      = 3'd2,
        ST_DOOR_CLOSE = 3'd3,
        ST_MOVE_UP    = 3'd4,
        ST_MOVE_DN    = 3'd5,
        ST_EMG        = 3'd6
    } car_state_e;

    typedef enum logic [1:0] {
        DIR_UP   = 2'd0,
        DIR_STOP = 2'd1,
        DIR_DN   = 2'd2
    } dir_e;

    // scheduler summary, recomputed every cycle
    typedef struct packed {
        logic any_above;
        logic any_below;
        logic stop_here;
        logic nearest_up;   // upper call nearer or tied
        logic clr_up;
        logic clr_dn;
    } sched_t;

endpackage

// ==== rtl/call_register.sv ====
`timescale 1ns/1ps

module call_register import elev_pkg::*; (
    input  logic       CLK,
    input  logic       RST_N,
    input  logic       call_valid,
    input  call_req_t  call,
    input  logic       open_enter,
    input  floor_t     cur_floor,
    input  sched_t     sched,
    output call_maps_t call_maps
);

    logic       in_range;
    call_maps_t set_maps;
    call_maps_t clr_maps;

    // floors 0 and 33..63 fall outside the building
    assign in_range = (call.floor >= MIN_FLOOR) && (call.floor <= MAX_FLOOR);

    // ************************************************************
    // decode new call, pick served bits
    // ************************************************************
    always_comb begin
        set_maps = '0;
        clr_maps = '0;
        for (int f = MIN_FLOOR; f <= MAX_FLOOR; f++) begin
            if (call_valid && in_range && (call.floor == f)) begin
                case (call.kind)
                    CALL_HALL_UP: set_maps.hall_up[f] = 1'b1;
                    CALL_HALL_DN: set_maps.hall_dn[f] = 1'b1;
                    CALL_CAR:     set_maps.car[f]     = 1'b1;
                    default:      set_maps            = '0;  // unused opcode
                endcase
            end
            // door starts opening here, so this floor is served
            if (open_enter && (cur_floor == f)) begin
                clr_maps.car[f]     = 1'b1;
                clr_maps.hall_up[f] = sched.clr_up;
                clr_maps.hall_dn[f] = sched.clr_dn;
            end
        end
    end

    // a call landing on the floor being opened is served at once
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            call_maps <= '0;
        end else begin
            call_maps <= (call_maps | set_maps) & ~clr_maps;
        end
    end

    // ************************************************************
    // checks
    // ************************************************************

    // any bit that turns on came from an in-range call one cycle back
    a_new_bit_from_valid_call : assert property (
        @(posedge CLK) disable iff (!RST_N)
        ((call_maps & ~$past(call_maps)) != '0) |-> $past(call_valid && in_range)
    );

endmodule

// ==== rtl/hall_scheduler.sv ====
`timescale 1ns/1ps

module hall_scheduler import elev_pkg::*; (
    input  call_maps_t call_maps,
    input  floor_t     cur_floor,
    input  dir_e       cur_dir,
    output sched_t     sched
);

    floor_map_t busy;          // any kind of call per floor
    logic       any_above;
    logic       any_below;
    floor_t     near_above;
    floor_t     near_below;
    floor_t     dist_up;
    floor_t     dist_dn;
    logic       nearest_up;
    logic       up_here;
    logic       dn_here;
    logic       car_here;
    logic       any_here;
    logic       stop_here;
    logic       clr_up;
    logic       clr_dn;

    assign busy = call_maps.hall_up | call_maps.hall_dn | call_maps.car;

    // ************************************************************
    // scan for nearest call on each side
    // ************************************************************
    always_comb begin
        any_above  = 1'b0;
        any_below  = 1'b0;
        near_above = cur_floor;
        near_below = cur_floor;
        for (int f = MIN_FLOOR; f <= MAX_FLOOR; f++) begin
            if (busy[f]) begin
                if ((f > cur_floor) && !any_above) begin   // first hit going up
                    near_above = floor_t'(f);
                    any_above  = 1'b1;
                end
                if (f < cur_floor) begin                   // last hit is closest
                    near_below = floor_t'(f);
                    any_below  = 1'b1;
                end
            end
        end
    end

    assign dist_up    = near_above - cur_floor;
    assign dist_dn    = cur_floor - near_below;
    assign nearest_up = any_above && (!any_below || (dist_up <= dist_dn));

    // calls at the current floor
    assign up_here  = call_maps.hall_up[cur_floor];
    assign dn_here  = call_maps.hall_dn[cur_floor];
    assign car_here = call_maps.car[cur_floor];
    assign any_here = up_here || dn_here || car_here;

    // hall calls count only in travel direction, unless this is the turn point
    assign stop_here = car_here
                    || (up_here && (cur_dir != DIR_DN))
                    || (dn_here && (cur_dir != DIR_UP))
                    || ((cur_dir == DIR_UP) && any_here && !any_above)
                    || ((cur_dir == DIR_DN) && any_here && !any_below);

    // ************************************************************
    // which hall call(s) the door opening serves
    // ************************************************************
    always_comb begin
        clr_up = up_here;
        clr_dn = dn_here;
        if (up_here && dn_here) begin
            case (cur_dir)
                DIR_UP: begin
                    clr_dn = !any_above;       // turn point takes both
                end
                DIR_DN: begin
                    clr_up = !any_below;
                end
                default: begin
                    if (any_above && !any_below) begin
                        clr_dn = 1'b0;
                    end else if (!any_above && any_below) begin
                        clr_up = 1'b0;
                    end else if (any_above && any_below) begin
                        // strictly nearer side, tie goes down
                        clr_up = (dist_up < dist_dn);
                        clr_dn = !(dist_up < dist_dn);
                    end
                end
            endcase
        end
    end

    assign sched = '{
        any_above:  any_above,
        any_below:  any_below,
        stop_here:  stop_here,
        nearest_up: nearest_up,
        clr_up:     clr_up,
        clr_dn:     clr_dn
    };

endmodule

// ==== rtl/car_fsm.sv ====
`timescale 1ns/1ps

module car_fsm import elev_pkg::*; (
    input  logic   CLK,
    input  logic   RST_N,
    input  logic   tick,
    input  logic   btn_open,
    input  logic   btn_close,
    input  logic   emg_stop,
    input  sched_t sched,
    output floor_t cur_floor,
    output dir_e   cur_dir,
    output logic   open_enter,
    output logic   motor_up,
    output logic   motor_dn,
    output logic   door_open,
    output logic   door_close,
    output dir_e   report_dir
);

    car_state_e            state;
    car_state_e            next_state;
    car_state_e            saved_state;    // state cut off by emergency
    dir_e                  next_dir;
    logic [TIMER_BITS-1:0] timer;
    logic [TIMER_BITS-1:0] saved_timer;
    logic [TIMER_BITS-1:0] load_value;
    logic                  load_timer;
    logic                  resume_pending;
    logic                  close_req;
    logic                  door_done;
    logic                  dwell_done;
    logic                  travel_done;

    // phase ends on the tick that completes its count
    assign door_done   = tick && (timer >= TIMER_BITS'(DOOR_TICKS - 1));
    assign dwell_done  = tick && (timer >= TIMER_BITS'(DWELL_TICKS - 1));
    assign travel_done = tick && (timer >= TIMER_BITS'(TRAVEL_TICKS - 1));

    // ************************************************************
    // next state
    // ************************************************************
    always_comb begin
        next_state = state;
        next_dir   = cur_dir;
        load_timer = 1'b0;
        load_value = '0;
        case (state)
            ST_IDLE: begin
                if (resume_pending) begin
                    next_state = saved_state;
                    if (saved_state == ST_MOVE_UP) begin
                        next_dir = DIR_UP;
                    end else if (saved_state == ST_MOVE_DN) begin
                        next_dir = DIR_DN;
                    end
                    // door motions restart, dwell and travel carry on
                    if (saved_state inside {ST_DWELL, ST_MOVE_UP, ST_MOVE_DN}) begin
                        load_timer = 1'b1;
                        load_value = saved_timer;
                    end
                end else if (sched.stop_here) begin
                    next_state = ST_DOOR_OPEN;
                end else if (cur_dir == DIR_UP) begin
                    if (sched.any_above) begin
                        next_state = ST_MOVE_UP;
                    end else if (sched.any_below) begin
                        next_state = ST_MOVE_DN;   // reverse
                        next_dir   = DIR_DN;
                    end else begin
                        next_dir   = DIR_STOP;
                    end
                end else if (cur_dir == DIR_DN) begin
                    if (sched.any_below) begin
                        next_state = ST_MOVE_DN;
                    end else if (sched.any_above) begin
                        next_state = ST_MOVE_UP;
                        next_dir   = DIR_UP;
                    end else begin
                        next_dir   = DIR_STOP;
                    end
                end else if (sched.nearest_up) begin  // at rest, tie goes up
                    next_state = ST_MOVE_UP;
                    next_dir   = DIR_UP;
                end else if (sched.any_below) begin
                    next_state = ST_MOVE_DN;
                    next_dir   = DIR_DN;
                end
            end
            ST_DOOR_OPEN: begin
                if (door_done) begin
                    next_state = (close_req || btn_close) ? ST_DOOR_CLOSE : ST_DWELL;
                end
            end
            ST_DWELL: begin
                if (btn_open) begin
                    next_state = ST_DWELL;        // held open
                end else if (btn_close || close_req || dwell_done) begin
                    next_state = ST_DOOR_CLOSE;
                end
            end
            ST_DOOR_CLOSE: begin
                if (btn_open) begin
                    next_state = ST_DOOR_OPEN;    // reopen
                end else if (door_done) begin
                    next_state = ST_IDLE;
                end
            end
            ST_MOVE_UP, ST_MOVE_DN: begin
                if (travel_done) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;             // emergency released
                next_dir   = DIR_STOP;
            end
        endcase
        if (emg_stop) begin
            next_state = ST_EMG;
            next_dir   = DIR_STOP;
            load_timer = 1'b0;
        end
    end

    assign open_enter = (next_state == ST_DOOR_OPEN) && (state != ST_DOOR_OPEN);

    // ************************************************************
    // state, timer, floor, latches
    // ************************************************************
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state          <= ST_IDLE;
            cur_dir        <= DIR_STOP;
            cur_floor      <= floor_t'(START_FLOOR);
            timer          <= '0;
            resume_pending <= 1'b0;
            close_req      <= 1'b0;
        end else begin
            state   <= next_state;
            cur_dir <= next_dir;

            if (next_state != state) begin
                timer <= load_timer ? load_value : '0;
            end else if (state inside {ST_DOOR_OPEN, ST_DOOR_CLOSE, ST_MOVE_UP, ST_MOVE_DN}) begin
                timer <= tick ? timer + 1'b1 : timer;
            end else if (state == ST_DWELL) begin
                timer <= btn_open ? '0 : (tick ? timer + 1'b1 : timer);
            end else begin
                timer <= '0;
            end

            // floor changes when the move completes
            if (state == ST_MOVE_UP && next_state == ST_IDLE && cur_floor < MAX_FLOOR) begin
                cur_floor <= cur_floor + 1'b1;
            end
            if (state == ST_MOVE_DN && next_state == ST_IDLE && cur_floor > MIN_FLOOR) begin
                cur_floor <= cur_floor - 1'b1;
            end

            if (emg_stop) begin
                resume_pending <= 1'b0;
            end else if (state == ST_EMG) begin
                resume_pending <= (saved_state != ST_IDLE);
            end else if (state == ST_IDLE) begin
                resume_pending <= 1'b0;            // consumed this cycle
            end

            if (emg_stop || next_state == ST_DOOR_CLOSE) begin
                close_req <= 1'b0;
            end else if (state == ST_DOOR_OPEN || state == ST_DWELL) begin
                if (btn_open) begin
                    close_req <= 1'b0;
                end else if (btn_close) begin
                    close_req <= 1'b1;
                end
            end
        end
    end

    // snapshot on emergency entry
    always_ff @(posedge CLK) begin
        if (next_state == ST_EMG && state != ST_EMG) begin
            saved_state <= state;
            saved_timer <= timer;
        end
    end

    // ************************************************************
    // drives from state
    // ************************************************************
    assign motor_up   = (state == ST_MOVE_UP);
    assign motor_dn   = (state == ST_MOVE_DN);
    assign door_open  = (state == ST_DOOR_OPEN) || (state == ST_DWELL);
    assign door_close = (state == ST_DOOR_CLOSE);

    always_comb begin
        case (state)
            ST_MOVE_UP: report_dir = DIR_UP;
            ST_MOVE_DN: report_dir = DIR_DN;
            default:    report_dir = DIR_STOP;
        endcase
    end

    // no direct reversal, motors pass through idle
    a_motor_excl : assert property (
        @(posedge CLK) disable iff (!RST_N)
        !(motor_up && motor_dn) && !(motor_up && $past(motor_dn))
            && !(motor_dn && $past(motor_up))
    );

    // door fully settled one cycle before any travel
    a_motor_door : assert property (
        @(posedge CLK) disable iff (!RST_N)
        (motor_up || motor_dn) |-> !(door_open || door_close)
            && !$past(door_open || door_close)
    );

    a_floor_range : assert property (
        @(posedge CLK) disable iff (!RST_N)
        (cur_floor >= MIN_FLOOR) && (cur_floor <= MAX_FLOOR)
    );

endmodule

// ==== rtl/elevator_top.sv ====
`timescale 1ns/1ps

module elevator_top import elev_pkg::*; (
    input  logic      CLK,
    input  logic      RST_N,
    input  logic      tick,
    input  logic      call_valid,
    input  call_req_t call,
    input  logic      btn_open,
    input  logic      btn_close,
    input  logic      emg_stop,
    output logic      motor_up,
    output logic      motor_dn,
    output logic      door_open,
    output logic      door_close,
    output floor_t    cur_floor,
    output dir_e      report_dir
);

    call_maps_t call_maps;
    sched_t     sched;
    dir_e       cur_dir;
    logic       open_enter;

    // ************************************************************
    // call bookkeeping
    // ************************************************************
    call_register u_call_register (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .call_valid (call_valid),
        .call       (call),
        .open_enter (open_enter),
        .cur_floor  (cur_floor),
        .sched      (sched),
        .call_maps  (call_maps)
    );

    hall_scheduler u_hall_scheduler (
        .call_maps (call_maps),
        .cur_floor (cur_floor),
        .cur_dir   (cur_dir),
        .sched     (sched)
    );

    // ************************************************************
    // car control
    // ************************************************************
    car_fsm u_car_fsm (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .tick       (tick),
        .btn_open   (btn_open),
        .btn_close  (btn_close),
        .emg_stop   (emg_stop),
        .sched      (sched),
        .cur_floor  (cur_floor),
        .cur_dir    (cur_dir),
        .open_enter (open_enter),
        .motor_up   (motor_up),
        .motor_dn   (motor_dn),
        .door_open  (door_open),
        .door_close (door_close),
        .report_dir (report_dir)
    );

endmodule

// ==== dv/tb_elevator.sv ====
`timescale 1ns/1ps

module tb_elevator import elev_pkg::*; ();

    logic      CLK;
    logic      RST_N;
    logic      tick;
    logic      call_valid;
    call_req_t call;
    logic      btn_open;
    logic      btn_close;
    logic      emg_stop;
    logic      motor_up;
    logic      motor_dn;
    logic      door_open;
    logic      door_close;
    floor_t    cur_floor;
    dir_e      report_dir;

    integer seed = 32'he995_c862;
    int     gap;
    int     floor_lo = MIN_FLOOR;   // allowed floor window
    int     floor_hi = MAX_FLOOR;
    int     limit_cycles;
    logic   limit_ready = 1'b0;
    int     error_count = 0;
    logic   resume_armed = 1'b0;   // a move was cut by emergency
    logic   cut_up;                // direction of that move

    elevator_top UUT (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .tick       (tick),
        .call_valid (call_valid),
        .call       (call),
        .btn_open   (btn_open),
        .btn_close  (btn_close),
        .emg_stop   (emg_stop),
        .motor_up   (motor_up),
        .motor_dn   (motor_dn),
        .door_open  (door_open),
        .door_close (door_close),
        .cur_floor  (cur_floor),
        .report_dir (report_dir)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // one-cycle tick after a random gap of 2..5 cycles
    initial begin
        @(posedge RST_N);
        forever begin
            gap = 2 + ($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge CLK);
            tick <= 1'b1;
            @(posedge CLK);
            tick <= 1'b0;
        end
    end

    // ************************************************************
    // compare and failure helpers
    // ************************************************************
    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string why);
        error_count++;
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // direction report and floor window hold on every cycle
    always @(negedge CLK) begin
        if (RST_N) begin
            if (motor_up) check_value("report_dir", DIR_UP, report_dir);
            if (motor_dn) check_value("report_dir", DIR_DN, report_dir);
            if (cur_floor < floor_lo || cur_floor > floor_hi) begin
                fail_run($sformatf("car left floors %0d to %0d, now at %0d",
                                   floor_lo, floor_hi, cur_floor));
            end
            // first travel after release keeps the interrupted direction
            if (emg_stop && (motor_up || motor_dn)) begin
                resume_armed = 1'b1;
                cut_up       = motor_up;
            end else if (!emg_stop && resume_armed && (motor_up || motor_dn)) begin
                resume_armed = 1'b0;
                check_value("motor_up", cut_up, motor_up);
            end
        end
    end

    // ************************************************************
    // vector commands
    // ************************************************************
    task automatic run_ticks(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge CLK);
            if (tick) seen++;
        end
        @(negedge CLK);
    endtask

    task automatic wait_for(input int fl, input int dopen, input int bound);
        int  seen;
        bit  done;
        seen = 0;
        done = 0;
        while (!done) begin
            @(negedge CLK);
            if (cur_floor == fl && door_open == dopen) begin
                done = 1;
            end else begin
                if (tick) seen++;
                if (seen > bound) begin
                    fail_run($sformatf("car did not reach floor %0d with door_open %0d",
                                       fl, dopen));
                end
            end
        end
    endtask

    task automatic place_call(input int kind, input int fl);
        @(posedge CLK);
        call_valid <= 1'b1;
        call       <= '{kind: call_kind_e'(kind), floor: floor_t'(fl)};
        @(posedge CLK);
        call_valid <= 1'b0;
    endtask

    task automatic check_now(input int fl, input int dir, input int mu, input int md,
                             input int dopen, input int dclose);
        if (fl != 0) check_value("cur_floor", fl, cur_floor);   // 0 means any floor
        check_value("report_dir", dir, report_dir);
        check_value("motor_up", mu, motor_up);
        check_value("motor_dn", md, motor_dn);
        check_value("door_open", dopen, door_open);
        check_value("door_close", dclose, door_close);
    endtask

    // watchdog sized from the vector file
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge CLK);
        fail_run("timeout, the vectors did not finish in time");
    end

    initial begin
        string line;
        byte   cmd;
        int    fd;
        int    n;
        int    total;
        int    a0, a1, a2, a3, a4, a5;

        RST_N      = 1'b0;
        tick       = 1'b0;
        call_valid = 1'b0;
        call       = '0;
        btn_open   = 1'b0;
        btn_close  = 1'b0;
        emg_stop   = 1'b0;

        // first pass only sums the tick budget
        total = 0;
        fd = $fopen("dv/elevator_vectors.txt", "r");
        if (fd == 0) fail_run("cannot open dv/elevator_vectors.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %d %d", cmd, a0, a1, a2);
                if (cmd == "r") total += a0;
                if (cmd == "w") total += a2;
            end
        end
        $fclose(fd);
        limit_cycles = total * 5 + 1000;
        limit_ready  = 1'b1;

        repeat (3) @(posedge CLK);
        RST_N <= 1'b1;
        @(negedge CLK);
        check_now(START_FLOOR, DIR_STOP, 0, 0, 0, 0);

        fd = $fopen("dv/elevator_vectors.txt", "r");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %d %d %d %d %d", cmd, a0, a1, a2, a3, a4, a5);
                case (cmd)
                    "c": place_call(a0, a1);
                    "b": begin
                        @(posedge CLK);
                        btn_open  <= a0[0];
                        btn_close <= a1[0];
                    end
                    "e": begin
                        @(posedge CLK);
                        emg_stop <= a0[0];
                    end
                    "r": run_ticks(a0);
                    "w": wait_for(a0, a1, a2);
                    "k": check_now(a0, a1, a2, a3, a4, a5);
                    "m": begin
                        floor_lo = a0;
                        floor_hi = a1;
                    end
                    default: fail_run($sformatf("unknown vector command in line: %s", line));
                endcase
            end
        end
        $fclose(fd);

        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/elev_pkg.sv
rtl/call_register.sv
rtl/hall_scheduler.sv
rtl/car_fsm.sv
rtl/elevator_top.sv
dv/tb_elevator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the elevator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_elevator \
    -f flist.f \
    -Mdir obj_dir

# the simulation may stop with a nonzero status; the log decides
./obj_dir/Vtb_elevator > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== dv/elevator_vectors.txt ====
# c kind floor | b open close | e level | r ticks | m lo hi | w floor door_open max_ticks
# k floor(0 = any) dir motor_up motor_dn door_open door_close; kind 0 up 1 dn 2 car; dir 0 up 1 stop 2 dn
m 1 4
c 2 4
w 4 1 30
m 1 32
c 2 1
w 1 1 40
c 1 6
r 6
c 2 3
w 3 1 40
w 6 1 40
c 2 5
w 5 1 30
r 8
k 5 1 0 0 0 0
e 1
c 2 8
c 2 3
e 0
w 3 1 30
w 8 1 40
r 8
k 8 1 0 0 0 0
e 1
c 2 10
c 2 6
e 0
m 8 10
w 10 1 30
m 1 32
w 6 1 40
b 1 0
r 10
w 6 1 2
k 6 1 0 0 1 0
b 0 1
w 6 0 10
k 6 1 0 0 0 1
b 0 0
r 3
k 6 1 0 0 0 0
m 6 12
c 2 12
r 3
e 1
r 2
k 0 1 0 0 0 0
e 0
w 12 1 60
r 8
k 12 1 0 0 0 0
c 2 0
c 0 33
r 6
k 12 1 0 0 0 0
